// File: source/fas_pkg.sv
// Sample and bin types, FIR coefficient table and FFT twiddle tables
`default_nettype none

package fas_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sample stream and FIR filter
  ////////////////////////////////////////////////////////////////////////////

  localparam int SAMPLE_W  = 16;                  // Input and filtered samples
  localparam int FIR_TAPS  = 32;
  localparam int COEF_FRAC = 16;                  // Coefficients are Q16

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [19:0]         coef_t;     // Sign, 3 integer and 16 fraction bits
  typedef logic signed [40:0]         acc_t;      // 36-bit products summed 32 times

  // Low-pass response with index 0 applied to the newest sample
  localparam coef_t FIR_COEF [FIR_TAPS] = '{
    20'hFFF9E, 20'hFFF86, 20'hFFFA7, 20'h0003B,   // Taps 0 to 3
    20'h0014B, 20'h0024A, 20'h00222, 20'hFFFE4,
    20'hFFBC5, 20'hFF7CA, 20'hFF74E, 20'hFFD74,
    20'h00B1A, 20'h01DAC, 20'h02F9E, 20'h03AA9,   // Centre peak near 0.229
    20'h03AA9, 20'h02F9E, 20'h01DAC, 20'h00B1A,   // Mirror of taps 15 down to 12
    20'hFFD74, 20'hFF74E, 20'hFF7CA, 20'hFFBC5,
    20'hFFFE4, 20'h00222, 20'h0024A, 20'h0014B,
    20'h0003B, 20'hFFFA7, 20'hFFF86, 20'hFFF9E
  };

  ////////////////////////////////////////////////////////////////////////////
  // 16-point FFT
  ////////////////////////////////////////////////////////////////////////////

  localparam int FFT_N        = 16;               // Points per frame
  localparam int FFT_STAGES   = 4;                // log2 of FFT_N
  localparam int TWIDDLE_FRAC = 16;

  typedef logic signed [17:0] twiddle_t;          // Q16 with room for +1.0 and -1.0

  // cos(2*pi*k/16) for k = 0 to 7
  localparam twiddle_t TWIDDLE_RE [FFT_N/2] = '{
    18'sd65536,  18'sd60547,  18'sd46340,  18'sd25079,
    18'sd0,     -18'sd25079, -18'sd46340, -18'sd60547
  };

  // -sin(2*pi*k/16) for k = 0 to 7
  localparam twiddle_t TWIDDLE_IM [FFT_N/2] = '{
     18'sd0,     -18'sd25079, -18'sd46340, -18'sd60547,
    -18'sd65536, -18'sd60547, -18'sd46340, -18'sd25079
  };

  // One bit of growth per butterfly stage
  localparam int BIN_W = SAMPLE_W + FFT_STAGES;

  typedef logic signed [BIN_W-1:0] bin_t;

endpackage

`default_nettype wire

// File: source/fir_filter.sv
// 32-tap FIR filter with sample history, multiply-accumulate and fill counter
`timescale 1ns/10ps
`default_nettype none

module fir_filter (
  input  logic             clk,
  input  logic             rst,
  input  logic             data_valid,
  input  fas_pkg::sample_t data,
  output logic             fir_valid,
  output fas_pkg::sample_t fir_d
);
  import fas_pkg::*;

  localparam int CNT_W = $clog2(FIR_TAPS + 1);    // Counts 0 to FIR_TAPS

  sample_t          hist   [FIR_TAPS-1];          // Held samples with hist[0] the newest
  sample_t          window [FIR_TAPS];            // Incoming sample followed by history
  acc_t             acc;
  logic [CNT_W-1:0] fill_cnt;
  logic             fill_done;

  ////////////////////////////////////////////////////////////////////////////
  // Convolution window and multiply-accumulate
  ////////////////////////////////////////////////////////////////////////////

  // The sample arriving now is tap 0, so the result is ready at this edge
  always_comb begin
    window[0] = data;
    for (int k = 1; k < FIR_TAPS; k++) begin
      window[k] = hist[k-1];
    end
  end

  always_comb begin
    acc = '0;
    for (int k = 0; k < FIR_TAPS; k++) begin
      acc = acc + acc_t'(FIR_COEF[k]) * acc_t'(window[k]);
    end
  end

  // This sample completes an unbroken run of FIR_TAPS
  assign fill_done = (fill_cnt >= CNT_W'(FIR_TAPS - 1));

  ////////////////////////////////////////////////////////////////////////////
  // Delay line
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int k = 0; k < FIR_TAPS - 1; k++) begin
        hist[k] <= '0;
      end
    end else if (data_valid) begin
      for (int k = 0; k < FIR_TAPS - 1; k++) begin
        hist[k] <= window[k];                     // Shift by one, oldest drops out
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Fill counter and output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fill_cnt  <= '0;
      fir_valid <= 1'b0;
      fir_d     <= '0;
    end else if (data_valid) begin
      if (fill_cnt != CNT_W'(FIR_TAPS)) begin
        fill_cnt <= fill_cnt + 1'b1;              // Saturates at FIR_TAPS
      end
      fir_valid <= fill_done;
      fir_d     <= sample_t'(acc >>> COEF_FRAC);  // Floor, then keep low 16 bits
    end else begin
      fill_cnt  <= '0;                            // Any gap restarts the fill
      fir_valid <= 1'b0;
    end
  end

  // An output strobe always comes from a sample accepted at the previous edge
  a_valid_from_input : assert property (
    @(posedge clk) disable iff (rst)
    fir_valid |-> $past(data_valid)
  );

endmodule

`default_nettype wire

// File: source/frame_collector.sv
// Frame collector that groups 16 filter outputs and flags each full frame
`timescale 1ns/10ps
`default_nettype none

module frame_collector (
  input  logic             clk,
  input  logic             rst,
  input  logic             fir_valid,
  input  fas_pkg::sample_t fir_d,
  output logic             frame_valid,
  output fas_pkg::sample_t frame [fas_pkg::FFT_N]
);
  import fas_pkg::*;

  localparam int SLOT_W = $clog2(FFT_N);

  logic [SLOT_W-1:0] slot;                        // Next slot to write
  logic              last_slot;

  assign last_slot = (slot == SLOT_W'(FFT_N - 1));

  // A partial frame waits through gaps in fir_valid
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      slot        <= '0;
      frame_valid <= 1'b0;
      for (int i = 0; i < FFT_N; i++) begin
        frame[i] <= '0;
      end
    end else begin
      frame_valid <= fir_valid && last_slot;      // One pulse per 16th sample
      if (fir_valid) begin
        frame[slot] <= fir_d;
        slot        <= slot + 1'b1;               // Wraps back to slot 0
      end
    end
  end

  // Back-to-back frame pulses need a sample accepted in each of the two cycles before
  a_frame_spacing : assert property (
    @(posedge clk) disable iff (rst)
    frame_valid && $past(frame_valid) |-> $past(fir_valid) && $past(fir_valid, 2)
  );

endmodule

`default_nettype wire

// File: source/fft_stage.sv
// Registered radix-2 decimation-in-frequency butterfly stage for the 16-point FFT
`timescale 1ns/10ps
`default_nettype none

module fft_stage #(
  parameter int STAGE = 0,
  parameter int IN_W  = fas_pkg::SAMPLE_W
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic signed [IN_W-1:0] in_re  [fas_pkg::FFT_N],
  input  logic signed [IN_W-1:0] in_im  [fas_pkg::FFT_N],
  output logic signed [IN_W:0]   out_re [fas_pkg::FFT_N],
  output logic signed [IN_W:0]   out_im [fas_pkg::FFT_N]
);
  import fas_pkg::*;

  localparam int OUT_W  = IN_W + 1;               // One bit of growth per stage
  localparam int SPAN   = (FFT_N / 2) >> STAGE;   // Distance between paired lanes
  localparam int PROD_W = OUT_W + $bits(twiddle_t);

  logic signed [OUT_W-1:0] nxt_re [FFT_N];
  logic signed [OUT_W-1:0] nxt_im [FFT_N];

  ////////////////////////////////////////////////////////////////////////////
  // Butterflies
  ////////////////////////////////////////////////////////////////////////////

  // Butterfly b sits at position POS inside group GRP of 2*SPAN lanes
  for (genvar b = 0; b < FFT_N / 2; b++) begin : g_bfly
    localparam int GRP = b / SPAN;
    localparam int POS = b % SPAN;
    localparam int TOP = GRP * 2 * SPAN + POS;
    localparam int BOT = TOP + SPAN;

    // Twiddle W16^(POS*2^STAGE)
    localparam twiddle_t W_RE = TWIDDLE_RE[POS << STAGE];
    localparam twiddle_t W_IM = TWIDDLE_IM[POS << STAGE];

    logic signed [OUT_W-1:0]  dif_re;
    logic signed [OUT_W-1:0]  dif_im;
    logic signed [PROD_W-1:0] prd_re;
    logic signed [PROD_W-1:0] prd_im;

    // Sum branch stays exact
    assign nxt_re[TOP] = in_re[TOP] + in_re[BOT];
    assign nxt_im[TOP] = in_im[TOP] + in_im[BOT];

    assign dif_re = in_re[TOP] - in_re[BOT];
    assign dif_im = in_im[TOP] - in_im[BOT];

    // Complex product with the twiddle
    assign prd_re = dif_re * W_RE - dif_im * W_IM;
    assign prd_im = dif_re * W_IM + dif_im * W_RE;

    // Back to the lane width, floored by the Q16 shift
    assign nxt_re[BOT] = OUT_W'(prd_re >>> TWIDDLE_FRAC);
    assign nxt_im[BOT] = OUT_W'(prd_im >>> TWIDDLE_FRAC);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////////////////////////////////////////

  // Every lane loads each cycle so a new frame can follow directly
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < FFT_N; i++) begin
        out_re[i] <= '0;
        out_im[i] <= '0;
      end
    end else begin
      for (int i = 0; i < FFT_N; i++) begin
        out_re[i] <= nxt_re[i];
        out_im[i] <= nxt_im[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/fft_core.sv
// Four-stage pipelined 16-point FFT with frame valid delay line
`timescale 1ns/10ps
`default_nettype none

module fft_core (
  input  logic             clk,
  input  logic             rst,
  input  logic             frame_valid,
  input  fas_pkg::sample_t frame  [fas_pkg::FFT_N],
  output logic             fft_valid,
  output fas_pkg::bin_t    fft_re [fas_pkg::FFT_N],
  output fas_pkg::bin_t    fft_im [fas_pkg::FFT_N]
);
  import fas_pkg::*;

  sample_t                   zero_im [FFT_N];     // Real input frame
  logic signed [SAMPLE_W:0]   s1_re [FFT_N];
  logic signed [SAMPLE_W:0]   s1_im [FFT_N];
  logic signed [SAMPLE_W+1:0] s2_re [FFT_N];
  logic signed [SAMPLE_W+1:0] s2_im [FFT_N];
  logic signed [SAMPLE_W+2:0] s3_re [FFT_N];
  logic signed [SAMPLE_W+2:0] s3_im [FFT_N];
  logic signed [SAMPLE_W+3:0] s4_re [FFT_N];
  logic signed [SAMPLE_W+3:0] s4_im [FFT_N];
  logic [FFT_STAGES-1:0]      vld_pipe;           // One bit per stage register

  assign zero_im = '{default: '0};

  ////////////////////////////////////////////////////////////////////////////
  // Butterfly stages
  ////////////////////////////////////////////////////////////////////////////

  fft_stage #(.STAGE(0), .IN_W(SAMPLE_W)) stage0_i (
    .clk(clk), .rst(rst),
    .in_re(frame), .in_im(zero_im),
    .out_re(s1_re), .out_im(s1_im)
  );

  fft_stage #(.STAGE(1), .IN_W(SAMPLE_W + 1)) stage1_i (
    .clk(clk), .rst(rst),
    .in_re(s1_re), .in_im(s1_im),
    .out_re(s2_re), .out_im(s2_im)
  );

  fft_stage #(.STAGE(2), .IN_W(SAMPLE_W + 2)) stage2_i (
    .clk(clk), .rst(rst),
    .in_re(s2_re), .in_im(s2_im),
    .out_re(s3_re), .out_im(s3_im)
  );

  fft_stage #(.STAGE(3), .IN_W(SAMPLE_W + 3)) stage3_i (
    .clk(clk), .rst(rst),
    .in_re(s3_re), .in_im(s3_im),
    .out_re(s4_re), .out_im(s4_im)
  );

  // Lane i carries bin bit-reverse(i) after the last DIF stage
  always_comb begin
    for (int i = 0; i < FFT_N; i++) begin
      fft_re[i] = bin_t'(s4_re[i]);
      fft_im[i] = bin_t'(s4_im[i]);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Valid alongside the data
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[FFT_STAGES-2:0], frame_valid};
    end
  end

  assign fft_valid = vld_pipe[FFT_STAGES-1];

  // Output strobe tracks the input frame through all four stages
  a_fft_latency : assert property (
    @(posedge clk) disable iff (rst)
    fft_valid == $past(frame_valid, FFT_STAGES)
  );

endmodule

`default_nettype wire

// File: source/fas_top.sv
// Analyser front end with FIR filter, frame collector and FFT core
`timescale 1ns/10ps
`default_nettype none

module fas_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             data_valid,
  input  fas_pkg::sample_t data,
  output logic             fir_valid,
  output fas_pkg::sample_t fir_d,
  output logic             fft_valid,
  output fas_pkg::bin_t    fft_re [fas_pkg::FFT_N],
  output fas_pkg::bin_t    fft_im [fas_pkg::FFT_N]
);
  import fas_pkg::*;

  logic    frame_valid;
  sample_t frame [FFT_N];                         // Collected frame into the FFT

  // Low-pass filter over the input stream
  fir_filter fir_i (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fir_valid  (fir_valid),
    .fir_d      (fir_d)
  );

  // 16 filtered samples per frame
  frame_collector coll_i (
    .clk         (clk),
    .rst         (rst),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

  // Bins leave 4 cycles after frame_valid
  fft_core fft_i (
    .clk         (clk),
    .rst         (rst),
    .frame_valid (frame_valid),
    .frame       (frame),
    .fft_valid   (fft_valid),
    .fft_re      (fft_re),
    .fft_im      (fft_im)
  );

endmodule

`default_nettype wire

// File: bench/fas_model.svh
// Reference model of the FIR convolution, fill counter, frame collection and expected bins
`ifndef FAS_MODEL_SVH
`define FAS_MODEL_SVH

sample_t mdl_hist [$];                            // Accepted samples, newest first
int      mdl_run;                                 // Unbroken run of accepted samples
sample_t mdl_frame [FFT_N];
int      mdl_slot;
bit      chk_q [$];                               // Per frame: bins predictable
bin_t    re0_q [$];
bin_t    re1_q [$];

task automatic model_clear();
  mdl_hist.delete();
  mdl_run  = 0;
  mdl_slot = 0;
  chk_q.delete();
  re0_q.delete();
  re1_q.delete();
endtask

// Floored, truncated convolution over the retained history
function automatic sample_t fir_expected();
  longint acc;
  acc = 0;
  for (int k = 0; k < mdl_hist.size(); k++) begin
    acc += longint'(FIR_COEF[k]) * longint'(mdl_hist[k]);
  end
  return sample_t'(acc >>> COEF_FRAC);
endfunction

// Only constant and alternating frames have bins predicted here
task automatic frame_bins();
  bit alt;
  alt = 1'b1;
  for (int i = 0; i < FFT_N; i++) begin
    if (mdl_frame[i] != mdl_frame[i % 2]) alt = 1'b0;
  end
  chk_q.push_back(alt);
  re0_q.push_back(bin_t'(8 * (int'(mdl_frame[0]) + int'(mdl_frame[1]))));
  re1_q.push_back(bin_t'(8 * (int'(mdl_frame[0]) - int'(mdl_frame[1]))));
endtask

`endif

// File: bench/fas_tb.sv
// Testbench for the analyser front end with model-driven concurrent checks
`timescale 1ns/10ps
`default_nettype none

module fas_tb;
  import fas_pkg::*;

  logic    clk;
  logic    rst;
  logic    data_valid;
  sample_t data;
  logic    fir_valid;
  sample_t fir_d;
  logic    fft_valid;
  bin_t    fft_re [FFT_N];
  bin_t    fft_im [FFT_N];

  string       test_name;
  int          err_cnt, test_cnt, fail_cnt, pulse_cnt, frame_cnt;
  int          start_err;                         // Error count when the test began
  bit          pend_valid, exp_fir_valid, exp_fft_valid, exp_chk;
  sample_t     pend_d, exp_fir_d;
  bin_t        exp_re0, exp_re1, bad_exp, bad_act;
  logic [5:0]  fft_pipe;                          // Frame done to fft_valid, 5 cycles
  int          bad_idx;

  `include "fas_model.svh"

  fas_top dut_i (.*);

  always #20 clk = ~clk;

  // First bin part that differs from the prediction
  always_comb begin
    bad_idx = -1;
    bad_exp = '0;
    bad_act = '0;
    for (int i = FFT_N - 1; i >= 0; i--) begin
      if (fft_im[i] != 0) begin
        bad_idx = i;
        bad_exp = 0;
        bad_act = fft_im[i];
      end
      if (fft_re[i] != (i == 0 ? exp_re0 : i == 1 ? exp_re1 : bin_t'(0))) begin
        bad_idx = i;
        bad_exp = (i == 0) ? exp_re0 : (i == 1) ? exp_re1 : bin_t'(0);
        bad_act = fft_re[i];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_fir_valid : assert property (@(posedge clk) disable iff (rst) fir_valid == exp_fir_valid)
    else begin
      err_cnt++;
      $display("ERROR %s: fir_valid expected %0d actual %0d", test_name, exp_fir_valid,
               $sampled(fir_valid));
    end

  a_fir_d : assert property (@(posedge clk) disable iff (rst) fir_valid |-> fir_d == exp_fir_d)
    else begin
      err_cnt++;
      $display("ERROR %s: fir_d expected %0d actual %0d", test_name, exp_fir_d, $sampled(fir_d));
    end

  a_fft_valid : assert property (@(posedge clk) disable iff (rst) fft_valid == exp_fft_valid)
    else begin
      err_cnt++;
      $display("ERROR %s: fft_valid expected %0d actual %0d", test_name, exp_fft_valid,
               $sampled(fft_valid));
    end

  a_fft_bins : assert property (@(posedge clk) disable iff (rst)
                                fft_valid && exp_chk |-> bad_idx < 0)
    else begin
      err_cnt++;
      $display("ERROR %s: bin slot %0d expected %0d actual %0d", test_name, $sampled(bad_idx),
               $sampled(bad_exp), $sampled(bad_act));
    end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // One falling edge: retire predictions, then drive the next input
  task automatic step(input bit v, input sample_t s);
    @(negedge clk);
    if (fft_valid) pulse_cnt++;
    exp_fir_valid = pend_valid;
    exp_fir_d     = pend_d;
    fft_pipe      = {fft_pipe[4:0], 1'b0};
    if (exp_fir_valid) begin
      mdl_frame[mdl_slot] = exp_fir_d;
      mdl_slot = (mdl_slot + 1) % FFT_N;
      if (mdl_slot == 0) begin
        frame_bins();
        fft_pipe[0] = 1'b1;
        frame_cnt++;
      end
    end
    if (fft_pipe[5]) begin
      exp_chk = chk_q.pop_front();
      exp_re0 = re0_q.pop_front();
      exp_re1 = re1_q.pop_front();
    end
    exp_fft_valid = fft_pipe[5];
    data_valid = v;
    data       = s;
    if (v) begin
      mdl_hist.push_front(s);
      if (mdl_hist.size() > FIR_TAPS) void'(mdl_hist.pop_back());
      mdl_run    = (mdl_run < FIR_TAPS) ? mdl_run + 1 : mdl_run;
      pend_valid = (mdl_run >= FIR_TAPS);
      pend_d     = fir_expected();
    end else begin
      mdl_run    = 0;
      pend_valid = 1'b0;
    end
  endtask

  task automatic start_test(input string name);
    @(negedge clk);
    rst        = 1'b1;
    data_valid = 1'b0;
    data       = '0;
    model_clear();
    {pend_valid, exp_fir_valid, exp_fft_valid, exp_chk} = '0;
    {pend_d, exp_fir_d, exp_re0, exp_re1} = '0;
    fft_pipe   = '0;
    repeat (3) @(negedge clk);
    rst        = 1'b0;
    test_name  = name;
    pulse_cnt  = 0;
    frame_cnt  = 0;
    start_err  = err_cnt;
    test_cnt++;
  endtask

  // Idle until every predicted frame has left the FFT
  task automatic end_test();
    int wait_cnt;
    wait_cnt  = 0;
    while (fft_pipe != 0 || pend_valid) begin
      if (wait_cnt == 40) begin
        $display("Timeout in %s: FFT pipeline did not drain within 40 cycles", test_name);
        $display("ERRORS FOUND");
        $finish;
      end
      step(1'b0, '0);
      wait_cnt++;
    end
    step(1'b0, '0);
    if (test_name == "pipelining") begin
      assert (pulse_cnt == frame_cnt && frame_cnt == 4)
      else begin
        err_cnt++;
        $display("ERROR %s: pulses expected %0d actual %0d", test_name, frame_cnt, pulse_cnt);
      end
    end
    if (err_cnt != start_err) fail_cnt++;
    $display("%s: %s", test_name, (err_cnt == start_err) ? "passed" : "failed");
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    data_valid = 1'b0;
    data = '0;
    err_cnt = 0;
    test_cnt = 0;
    fail_cnt = 0;
    start_err = 0;
    void'($urandom(92));

    start_test("reset");
    repeat (4) step(1'b0, '0);
    for (int i = 0; i < FIR_TAPS - 1; i++) step(1'b1, sample_t'($urandom));
    end_test();

    start_test("filter values");
    for (int i = 0; i < 200; i++) step(1'b1, sample_t'($urandom));
    end_test();

    start_test("gap restart");
    for (int i = 0; i < 40; i++) step(1'b1, sample_t'($urandom));
    step(1'b0, '0);                               // Single gap cycle
    for (int i = 0; i < 40; i++) step(1'b1, sample_t'($urandom));
    end_test();

    start_test("constant frame");
    for (int i = 0; i < FIR_TAPS - 1 + 2 * FFT_N; i++) step(1'b1, 16'sd12000);
    end_test();

    start_test("alternating frame");
    for (int i = 0; i < FIR_TAPS - 1 + 2 * FFT_N; i++) begin
      step(1'b1, (i % 2) ? -16'sd9000 : 16'sd9000);
    end
    end_test();

    start_test("pipelining");
    for (int i = 0; i < FIR_TAPS - 1 + 4 * FFT_N; i++) begin
      step(1'b1, (i % 2) ? -16'sd7000 : 16'sd7000);
    end
    end_test();

    $display("Tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+bench
source/fas_pkg.sv
source/fir_filter.sv
source/frame_collector.sv
source/fft_stage.sv
source/fft_core.sv
source/fas_top.sv
bench/fas_tb.sv
